//--- rtl/pacman_pkg.sv
package pacman_pkg;

    // Raster timing in 50 MHz clocks, each pixel spans two
    localparam logic [10:0] H_TOTAL      = 11'd1600;
    localparam logic [10:0] H_ACTIVE     = 11'd1280;
    localparam logic [10:0] H_SYNC_START = 11'd1312;
    localparam logic [10:0] H_SYNC_END   = 11'd1504;

    localparam logic [9:0] V_TOTAL      = 10'd525;
    localparam logic [9:0] V_ACTIVE     = 10'd480;
    localparam logic [9:0] V_SYNC_START = 10'd490;
    localparam logic [9:0] V_SYNC_END   = 10'd492;

    localparam logic [12:0] MAP_COLS  = 13'd80;
    localparam logic [12:0] MAP_ROWS  = 13'd60;
    localparam logic [12:0] MAP_SIZE  = MAP_COLS * MAP_ROWS;
    localparam logic [9:0]  TILE_PX   = 10'd8;
    localparam logic [9:0]  SPRITE_PX = 10'd16;

    localparam logic [9:0]  PACMAN_RESET_X       = 10'd340;
    localparam logic [9:0]  PACMAN_RESET_Y       = 10'd240;
    localparam int unsigned ROTATE_TICKS_DEFAULT = 50_000_000;

    localparam int          NUM_GHOSTS = 4;
    localparam logic [9:0]  GHOST_X [NUM_GHOSTS] = '{10'd100, 10'd200, 10'd300, 10'd400};
    localparam logic [9:0]  GHOST_Y = 10'd100;

    // Red, pink, orange, light blue
    localparam logic [23:0] GHOST_COLOR [NUM_GHOSTS] =
        '{24'hFF0000, 24'hFFB8FF, 24'hFFB852, 24'h00FFFF};
    localparam logic [23:0] YELLOW    = 24'hFFFF00;
    localparam logic [23:0] WHITE     = 24'hFFFFFF;
    localparam logic [23:0] DARK_BLUE = 24'h000088;
    localparam logic [23:0] WALL_BLUE = 24'h0000FF;

    localparam logic [1:0] ADDR_X    = 2'd0;
    localparam logic [1:0] ADDR_Y    = 2'd1;
    localparam logic [1:0] ADDR_DIR  = 2'd2;
    localparam logic [1:0] ADDR_TILE = 2'd3;

    // Blank, horizontal, vertical, four corners, pellet
    localparam logic [7:0] TILE_SHAPES [8][8] = '{
        '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'hFF, 8'hFF, 8'h00, 8'h00, 8'h00},
        '{8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18},
        '{8'h00, 8'h00, 8'h00, 8'h1F, 8'h1F, 8'h18, 8'h18, 8'h18},
        '{8'h00, 8'h00, 8'h00, 8'hF8, 8'hF8, 8'h18, 8'h18, 8'h18},
        '{8'h18, 8'h18, 8'h18, 8'h1F, 8'h1F, 8'h00, 8'h00, 8'h00},
        '{8'h18, 8'h18, 8'h18, 8'hF8, 8'hF8, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'h18, 8'h18, 8'h00, 8'h00, 8'h00}
    };

    // 0 transparent, 1 body, 2 eye white, 3 pupil
    localparam logic [1:0] GHOST_SHAPE [16][16] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0},
        '{0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0},
        '{0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0},
        '{0, 1, 1, 2, 2, 2, 1, 1, 1, 2, 2, 2, 1, 1, 1, 0},
        '{0, 1, 1, 2, 3, 3, 1, 1, 1, 2, 3, 3, 1, 1, 1, 0},
        '{1, 1, 1, 2, 3, 3, 1, 1, 1, 2, 3, 3, 1, 1, 1, 1},
        '{1, 1, 1, 2, 2, 2, 1, 1, 1, 2, 2, 2, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
        '{1, 1, 0, 1, 1, 1, 0, 1, 1, 0, 1, 1, 1, 0, 1, 1},
        '{1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1},
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
    };

    // Facing right, leftmost column in bit 15
    localparam logic [15:0] PACMAN_SHAPE [16] = '{
        16'b0000000000000000,
        16'b0000011111000000,
        16'b0001111111110000,
        16'b0011111111111000,
        16'b0111111111110000,
        16'b0111111111100000,
        16'b1111111111000000,
        16'b1111111110000000,
        16'b1111111110000000,
        16'b1111111111000000,
        16'b0111111111100000,
        16'b0111111111110000,
        16'b0011111111111000,
        16'b0001111111110000,
        16'b0000011111000000,
        16'b0000000000000000
    };

    typedef enum logic [1:0] {
        UP    = 2'd0,
        RIGHT = 2'd1,
        DOWN  = 2'd2,
        LEFT  = 2'd3
    } dir_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hs;
        logic        vs;
        logic        active;
    } raster_t;

    localparam raster_t RASTER_IDLE =
        '{hcount: '0, vcount: '0, hs: 1'b1, vs: 1'b1, active: 1'b0};

    typedef union packed {
        struct packed {
            logic [5:0] pad;
            logic [9:0] value;
        } coord;
        struct packed {
            logic [13:0] pad;
            dir_t        dir;
        } heading;
        struct packed {
            logic [2:0]  code;
            logic [12:0] index;
        } tile;
    } bus_word_u;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        dir_t       dir;
    } pacman_t;

    typedef struct packed {
        logic        en;
        logic [12:0] index;
        logic [2:0]  code;
    } tile_wr_t;

    typedef struct packed {
        raster_t raster;
        logic    tile_on;
    } fetch_t;

    typedef struct packed {
        raster_t    raster;
        logic       tile_on;
        logic [1:0] ghost_code;
        logic [1:0] ghost_idx;
        logic       pacman_on;
    } hit_t;

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/10ps

module vga_timing import pacman_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output raster_t raster,
    output logic    vga_clk
);

    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        line_end;

    assign line_end = (hcount == H_TOTAL - 11'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            if (vcount == V_TOTAL - 10'd1) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Sync levels are low inside their windows
    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        raster.hs     = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
        raster.vs     = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));
        raster.active = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    end

    // Pixel clock runs at half the system clock
    assign vga_clk = hcount[0];

    a_counters_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        (hcount < H_TOTAL) && (vcount < V_TOTAL)
    );

endmodule

//--- rtl/control_regs.sv
`timescale 1ns/10ps

module control_regs import pacman_pkg::*; #(
    parameter int unsigned ROTATE_TICKS = ROTATE_TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       chipselect,
    input  logic       write,
    input  logic [1:0] address,
    input  bus_word_u  writedata,
    output pacman_t    pacman,
    output tile_wr_t   tile_wr
);

    localparam int CNT_W = $clog2(ROTATE_TICKS + 1);

    logic             wr_en;
    logic             dir_wr;
    logic             rotate_tick;
    logic [CNT_W-1:0] rotate_count;

    assign wr_en       = chipselect && write;
    assign dir_wr      = wr_en && (address == ADDR_DIR);
    assign rotate_tick = (rotate_count == CNT_W'(ROTATE_TICKS - 1));

    // Straight to the map, one cycle wide
    assign tile_wr.en    = wr_en && (address == ADDR_TILE);
    assign tile_wr.index = writedata.tile.index;
    assign tile_wr.code  = writedata.tile.code;

    // Free running from reset, bus writes never touch it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rotate_count <= '0;
        end else if (rotate_tick) begin
            rotate_count <= '0;
        end else begin
            rotate_count <= rotate_count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pacman.x   <= PACMAN_RESET_X;
            pacman.y   <= PACMAN_RESET_Y;
            pacman.dir <= RIGHT;
        end else begin
            if (wr_en && (address == ADDR_X)) begin
                pacman.x <= writedata.coord.value;
            end
            if (wr_en && (address == ADDR_Y)) begin
                pacman.y <= writedata.coord.value;
            end
            // Software heading beats the quarter turn
            if (dir_wr) begin
                pacman.dir <= writedata.heading.dir;
            end else if (rotate_tick) begin
                pacman.dir <= dir_t'(pacman.dir + 2'd1);
            end
        end
    end

    a_tile_index_in_map: assert property (
        @(posedge clk) disable iff (reset)
        tile_wr.en |-> (tile_wr.index < MAP_SIZE)
    );

endmodule

//--- rtl/tile_fetch.sv
`timescale 1ns/10ps

module tile_fetch import pacman_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  raster_t  raster,
    input  tile_wr_t tile_wr,
    output fetch_t   fetch
);

    // Map starts blank
    logic [2:0]  tile_map [MAP_SIZE] = '{default: 3'd0};
    logic [9:0]  px;
    logic [9:0]  py;
    logic [12:0] map_idx;
    logic [2:0]  code;
    logic [7:0]  shape_row;
    logic        pixel_on;

    always_ff @(posedge clk) begin
        if (tile_wr.en) begin
            tile_map[tile_wr.index] <= tile_wr.code;
        end
    end

    assign px = raster.hcount[10:1];
    assign py = raster.vcount;

    assign map_idx = 13'(py / TILE_PX) * MAP_COLS + 13'(px / TILE_PX);

    // Map only covers the visible area
    assign code = raster.active ? tile_map[map_idx] : 3'd0;

    // Leftmost pixel is the MSB of the shape row
    assign shape_row = TILE_SHAPES[code][3'(py % TILE_PX)];
    assign pixel_on  = shape_row[3'd7 - 3'(px % TILE_PX)];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch <= '{raster: RASTER_IDLE, tile_on: 1'b0};
        end else begin
            fetch <= '{raster: raster, tile_on: pixel_on};
        end
    end

endmodule

//--- rtl/sprite_hit.sv
`timescale 1ns/10ps

module sprite_hit import pacman_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  fetch_t  fetch,
    input  pacman_t pacman,
    output hit_t    hit
);

    logic [9:0] px;
    logic [9:0] py;
    logic [9:0] ghost_dy;
    logic       ghost_band;
    logic [9:0] ghost_dx;
    logic [1:0] shape_code;
    logic [1:0] ghost_code;
    logic [1:0] ghost_idx;
    logic [9:0] pac_dx;
    logic [9:0] pac_dy;
    logic       pac_box;
    logic [3:0] pac_row;
    logic [3:0] pac_col;
    logic       pacman_on;

    assign px = fetch.raster.hcount[10:1];
    assign py = fetch.raster.vcount;

    // All ghosts sit on the same rows
    assign ghost_dy   = py - GHOST_Y;
    assign ghost_band = (py >= GHOST_Y) && (ghost_dy < SPRITE_PX);

    always_comb begin
        ghost_code = 2'd0;
        ghost_idx  = 2'd0;
        ghost_dx   = '0;
        shape_code = 2'd0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            ghost_dx   = px - GHOST_X[g];
            shape_code = GHOST_SHAPE[ghost_dy[3:0]][ghost_dx[3:0]];
            // Higher index wins where it is not transparent
            if (ghost_band && (px >= GHOST_X[g]) && (ghost_dx < SPRITE_PX)
                && (shape_code != 2'd0)) begin
                ghost_code = shape_code;
                ghost_idx  = 2'(g);
            end
        end
    end

    assign pac_dx  = px - pacman.x;
    assign pac_dy  = py - pacman.y;
    assign pac_box = (px >= pacman.x) && (pac_dx < SPRITE_PX)
                  && (py >= pacman.y) && (pac_dy < SPRITE_PX);

    // Mirror for left, transpose for down and up
    always_comb begin
        case (pacman.dir)
            RIGHT: begin
                pac_row = pac_dy[3:0];
                pac_col = pac_dx[3:0];
            end
            LEFT: begin
                pac_row = pac_dy[3:0];
                pac_col = 4'd15 - pac_dx[3:0];
            end
            DOWN: begin
                pac_row = pac_dx[3:0];
                pac_col = pac_dy[3:0];
            end
            UP: begin
                pac_row = pac_dx[3:0];
                pac_col = 4'd15 - pac_dy[3:0];
            end
        endcase
    end

    assign pacman_on = pac_box && PACMAN_SHAPE[pac_row][4'd15 - pac_col];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit <= '{raster: RASTER_IDLE, default: '0};
        end else begin
            hit.raster     <= fetch.raster;
            hit.tile_on    <= fetch.tile_on;
            hit.ghost_code <= ghost_code;
            hit.ghost_idx  <= ghost_idx;
            hit.pacman_on  <= pacman_on;
        end
    end

endmodule

//--- rtl/pixel_compose.sv
`timescale 1ns/10ps

module pixel_compose import pacman_pkg::*; (
    input  hit_t       hit,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_blank_n,
    output logic       vga_sync_n
);

    logic [23:0] color;

    // Walls under ghosts under Pac-Man
    always_comb begin
        color = 24'h000000;
        if (hit.tile_on) begin
            color = WALL_BLUE;
        end
        case (hit.ghost_code)
            2'd1:    color = GHOST_COLOR[hit.ghost_idx];
            2'd2:    color = WHITE;
            2'd3:    color = DARK_BLUE;
            default: ;
        endcase
        if (hit.pacman_on) begin
            color = YELLOW;
        end
        if (!hit.raster.active) begin
            color = 24'h000000;
        end
    end

    assign {vga_r, vga_g, vga_b} = color;

    assign vga_hs      = hit.raster.hs;
    assign vga_vs      = hit.raster.vs;
    assign vga_blank_n = hit.raster.active;
    assign vga_sync_n  = 1'b0;

    // Sampled once per pixel on the delayed pixel clock
    a_black_in_blanking: assert property (
        @(posedge hit.raster.hcount[0])
        !vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h000000)
    );

endmodule

//--- rtl/pacman_video.sv
`timescale 1ns/10ps

module pacman_video import pacman_pkg::*; #(
    parameter int unsigned ROTATE_TICKS = ROTATE_TICKS_DEFAULT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [1:0]  address,
    input  logic [15:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_sync_n
);

    raster_t  raster;
    fetch_t   fetch;
    hit_t     hit;
    pacman_t  pacman;
    tile_wr_t tile_wr;

    vga_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .raster  (raster),
        .vga_clk (vga_clk)
    );

    control_regs #(
        .ROTATE_TICKS (ROTATE_TICKS)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .pacman     (pacman),
        .tile_wr    (tile_wr)
    );

    // Two register stages from counters to pins
    tile_fetch u_fetch (
        .clk     (clk),
        .reset   (reset),
        .raster  (raster),
        .tile_wr (tile_wr),
        .fetch   (fetch)
    );

    sprite_hit u_sprite (
        .clk    (clk),
        .reset  (reset),
        .fetch  (fetch),
        .pacman (pacman),
        .hit    (hit)
    );

    pixel_compose u_compose (
        .hit         (hit),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

endmodule

//--- test/tb_pacman_video.sv
`timescale 1ns/10ps

module tb_pacman_video import pacman_pkg::*; ();

    localparam int FRAME_CYCLES = 840_000;
    localparam int WATCHDOG_NS  = 6 * FRAME_CYCLES * 20;
    localparam logic [9:0] NEW_X = 10'd500;
    localparam logic [9:0] NEW_Y = 10'd300;

    typedef struct packed {
        logic [23:0] rgb;
        logic        hs;
        logic        vs;
        logic        blank_n;
    } pixel_t;

    localparam pixel_t IDLE_PIXEL = '{rgb: 24'h0, hs: 1'b1, vs: 1'b1, blank_n: 1'b0};

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [1:0]  address;
    logic [15:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    integer seed;
    int     errors  = 0;
    int     checked = 0;

    // Reference model state
    logic [10:0] m_h;
    logic [9:0]  m_v;
    int          m_frame;
    logic [19:0] m_rot;
    logic [9:0]  m_x;
    logic [9:0]  m_y;
    dir_t        m_dir;
    logic [2:0]  m_map [MAP_SIZE] = '{default: 3'd0};
    pixel_t      exp_d1;
    pixel_t      exp_d2;
    logic        bus_wr;

    pacman_video #(
        .ROTATE_TICKS (FRAME_CYCLES)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign bus_wr = chipselect && write;

    function automatic void report_mismatch(input string name, input logic [23:0] expected,
                                            input logic [23:0] actual);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expected, actual);
        errors++;
    endfunction

    // Expected output for counter values (h, v) from the current model state
    function automatic pixel_t expected_pixel(input logic [10:0] h, input logic [9:0] v);
        pixel_t      p;
        logic [9:0]  px;
        logic [12:0] idx;
        logic [7:0]  tile_row;
        logic [1:0]  gcode;
        logic [1:0]  gidx;
        logic [3:0]  lx;
        logic [3:0]  ly;
        logic [3:0]  row;
        logic [3:0]  col;
        logic        pac_on;
        p.hs      = !((h >= H_SYNC_START) && (h < H_SYNC_END));
        p.vs      = !((v >= V_SYNC_START) && (v < V_SYNC_END));
        p.blank_n = (h < H_ACTIVE) && (v < V_ACTIVE);
        p.rgb     = 24'h0;
        px        = h[10:1];
        if (p.blank_n) begin
            idx      = 13'(v[9:3]) * 13'd80 + 13'(px[9:3]);
            tile_row = TILE_SHAPES[m_map[idx]][v[2:0]];
            if (tile_row[3'd7 - px[2:0]]) begin
                p.rgb = WALL_BLUE;
            end
            gcode = 2'd0;
            gidx  = 2'd0;
            for (int g = 0; g < NUM_GHOSTS; g++) begin
                lx = 4'(px - GHOST_X[g]);
                ly = 4'(v - GHOST_Y);
                if ((px >= GHOST_X[g]) && (px < GHOST_X[g] + 10'd16) && (v >= GHOST_Y)
                    && (v < GHOST_Y + 10'd16) && (GHOST_SHAPE[ly][lx] != 2'd0)) begin
                    gcode = GHOST_SHAPE[ly][lx];
                    gidx  = 2'(g);
                end
            end
            if (gcode == 2'd1) p.rgb = GHOST_COLOR[gidx];
            if (gcode == 2'd2) p.rgb = WHITE;
            if (gcode == 2'd3) p.rgb = DARK_BLUE;
            lx = 4'(px - m_x);
            ly = 4'(v - m_y);
            case (m_dir)
                RIGHT: begin
                    row = ly;
                    col = lx;
                end
                LEFT: begin
                    row = ly;
                    col = 4'd15 - lx;
                end
                DOWN: begin
                    row = lx;
                    col = ly;
                end
                default: begin
                    row = lx;
                    col = 4'd15 - ly;
                end
            endcase
            pac_on = (px >= m_x) && (px < m_x + 10'd16) && (v >= m_y) && (v < m_y + 10'd16)
                     && PACMAN_SHAPE[row][4'd15 - col];
            if (pac_on) p.rgb = YELLOW;
        end
        return p;
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_h     <= '0;
            m_v     <= '0;
            m_frame <= 0;
        end else if (m_h == H_TOTAL - 11'd1) begin
            m_h <= '0;
            if (m_v == V_TOTAL - 10'd1) begin
                m_v     <= '0;
                m_frame <= m_frame + 1;
            end else begin
                m_v <= m_v + 10'd1;
            end
        end else begin
            m_h <= m_h + 11'd1;
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_x   <= PACMAN_RESET_X;
            m_y   <= PACMAN_RESET_Y;
            m_dir <= RIGHT;
            m_rot <= '0;
        end else begin
            m_rot <= (m_rot == 20'(FRAME_CYCLES - 1)) ? 20'd0 : m_rot + 20'd1;
            if (bus_wr && (address == ADDR_X)) m_x <= writedata[9:0];
            if (bus_wr && (address == ADDR_Y)) m_y <= writedata[9:0];
            if (bus_wr && (address == ADDR_DIR)) begin
                m_dir <= dir_t'(writedata[1:0]);
            end else if (m_rot == 20'(FRAME_CYCLES - 1)) begin
                m_dir <= dir_t'(m_dir + 2'd1);
            end
        end
    end

    always @(posedge clk) begin
        if (bus_wr && (address == ADDR_TILE)) begin
            m_map[writedata[12:0]] <= writedata[15:13];
        end
    end

    // Two stage delay to line up with the DUT pipeline
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_d1 <= IDLE_PIXEL;
            exp_d2 <= IDLE_PIXEL;
        end else begin
            exp_d1  <= expected_pixel(m_h, m_v);
            exp_d2  <= exp_d1;
            checked <= checked + 1;
        end
    end

    a_hs: assert property (@(posedge clk) disable iff (reset) vga_hs == exp_d2.hs)
        else report_mismatch("vga_hs", 24'($sampled(exp_d2.hs)), 24'($sampled(vga_hs)));
    a_vs: assert property (@(posedge clk) disable iff (reset) vga_vs == exp_d2.vs)
        else report_mismatch("vga_vs", 24'($sampled(exp_d2.vs)), 24'($sampled(vga_vs)));
    a_blank: assert property (@(posedge clk) disable iff (reset) vga_blank_n == exp_d2.blank_n)
        else report_mismatch("vga_blank_n", 24'($sampled(exp_d2.blank_n)),
                             24'($sampled(vga_blank_n)));
    a_sync: assert property (@(posedge clk) disable iff (reset) vga_sync_n == 1'b0)
        else report_mismatch("vga_sync_n", 24'h0, 24'($sampled(vga_sync_n)));
    a_pix_clk: assert property (@(posedge clk) disable iff (reset) vga_clk == m_h[0])
        else report_mismatch("vga_clk", 24'($sampled(m_h[0])), 24'($sampled(vga_clk)));
    a_rgb: assert property (@(posedge clk) disable iff (reset) {vga_r, vga_g, vga_b} == exp_d2.rgb)
        else report_mismatch("vga_rgb", $sampled(exp_d2.rgb), $sampled({vga_r, vga_g, vga_b}));
    a_blank_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h0))
        else report_mismatch("vga_rgb_blanked", 24'h0, $sampled({vga_r, vga_g, vga_b}));

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic wait_for_row(input int frame, input logic [9:0] row);
        do begin
            @(posedge clk);
            #1;
        end while (!((m_frame == frame) && (m_v == row) && (m_h == 11'd0)));
    endtask

    // First tiles land under the ghosts and Pac-Man, the rest anywhere
    task automatic place_tiles();
        logic [2:0]  code;
        logic [12:0] idx;
        int          col;
        int          row;
        for (int i = 0; i < 20; i++) begin
            code = 3'({$random(seed)} % 32'd7 + 32'd1);
            if (i < 4) begin
                col = (int'(GHOST_X[i[1:0]]) + 4) / 8;
                row = int'(GHOST_Y) / 8 + (i % 2);
                idx = 13'(row * 80 + col);
            end else if (i < 8) begin
                col = int'(NEW_X) / 8 + (i % 2);
                row = int'(NEW_Y) / 8 + (i - 4) / 2;
                idx = 13'(row * 80 + col);
            end else begin
                idx = 13'({$random(seed)} % 32'(MAP_SIZE));
            end
            write_reg(ADDR_TILE, {code, idx});
        end
    endtask

    initial begin
        seed       = 2;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = 2'd0;
        writedata  = 16'd0;
        reset      = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // Frame 0 untouched, then move during its vertical blanking
        wait_for_row(0, V_ACTIVE);
        write_reg(ADDR_X, 16'hA400 | 16'(NEW_X));
        write_reg(ADDR_Y, 16'(NEW_Y));
        // Headings chosen so frames 2 and 3 show up and left
        wait_for_row(1, V_ACTIVE);
        write_reg(ADDR_DIR, 16'(LEFT));
        wait_for_row(2, V_ACTIVE);
        write_reg(ADDR_DIR, 16'(DOWN));
        place_tiles();
        // Let frame 3 drain out of the pipeline
        wait_for_row(4, 10'd1);
        repeat (4) @(posedge clk);

        $display("Checked %0d cycles, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within six frame times");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
rtl/pacman_pkg.sv
rtl/vga_timing.sv
rtl/control_regs.sv
rtl/tile_fetch.sv
rtl/sprite_hit.sv
rtl/pixel_compose.sv
rtl/pacman_video.sv
test/tb_pacman_video.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pacman_video
RTL_TOP   ?= pacman_video
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
